// ==== logic/lc3b_pkg.sv ====
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [3:0]  lc3b_opcode;

    localparam lc3b_opcode OP_BR   = 4'b0000;
    localparam lc3b_opcode OP_ADD  = 4'b0001;
    localparam lc3b_opcode OP_LDB  = 4'b0010;
    localparam lc3b_opcode OP_STB  = 4'b0011;
    localparam lc3b_opcode OP_JSR  = 4'b0100;
    localparam lc3b_opcode OP_AND  = 4'b0101;
    localparam lc3b_opcode OP_LDR  = 4'b0110;
    localparam lc3b_opcode OP_STR  = 4'b0111;
    localparam lc3b_opcode OP_RTI  = 4'b1000;
    localparam lc3b_opcode OP_NOT  = 4'b1001;
    localparam lc3b_opcode OP_LDI  = 4'b1010;
    localparam lc3b_opcode OP_STI  = 4'b1011;
    localparam lc3b_opcode OP_JMP  = 4'b1100;
    localparam lc3b_opcode OP_SHF  = 4'b1101;
    localparam lc3b_opcode OP_LEA  = 4'b1110;
    localparam lc3b_opcode OP_TRAP = 4'b1111;

    localparam logic [2:0] ALU_ADD  = 3'd0;
    localparam logic [2:0] ALU_AND  = 3'd1;
    localparam logic [2:0] ALU_NOT  = 3'd2;
    localparam logic [2:0] ALU_PASS = 3'd3;
    localparam logic [2:0] ALU_SHF  = 3'd4;

    typedef struct packed {
        logic [2:0] alu_op;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       uses_imm;
        logic       is_trap;
    } lc3b_control_word;

    // Register form: ADD, AND, NOT, SHF, loads and stores with base register.
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dest;
        lc3b_reg    src1;
        logic       imm_flag;
        logic [4:0] low;
    } lc3b_rform_t;

    // Offset form: BR, LEA, LDI, JSR and TRAP.
    typedef struct packed {
        lc3b_opcode opcode;
        logic [2:0] nzp;
        logic [8:0] offset9;
    } lc3b_oform_t;

    typedef union packed {
        lc3b_rform_t rform;
        lc3b_oform_t oform;
    } lc3b_instr_u;

    typedef struct packed {
        lc3b_word    pc;
        lc3b_instr_u instr;
    } fetch_packet_t;

    typedef struct packed {
        lc3b_word         pc;
        lc3b_reg          dest;
        lc3b_reg          src1;
        lc3b_reg          src2;
        lc3b_word         imm5;
        lc3b_word         imm4;
        lc3b_word         offset6;
        lc3b_word         offset9;
        lc3b_word         offset11;
        lc3b_word         trapvect8;
        lc3b_control_word ctrl;
    } decode_packet_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        lc3b_word adr;  // Word address.
        lc3b_word dat_w;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        lc3b_word dat_r;
    } wb_rsp_t;

endpackage : lc3b_pkg

// ==== logic/control_rom.sv ====
`timescale 1ns/10ps

module control_rom
(
    input  lc3b_pkg::lc3b_opcode       opcode,
    output lc3b_pkg::lc3b_control_word ctrl
);

always_comb
begin
    ctrl = '0;
    case (opcode)
        lc3b_pkg::OP_BR:
        begin
            ctrl.alu_op = lc3b_pkg::ALU_ADD;  // Target is pc plus offset9.
            ctrl.branch = 1'b1;
        end
        lc3b_pkg::OP_ADD, lc3b_pkg::OP_AND, lc3b_pkg::OP_NOT:
        begin
            if (opcode == lc3b_pkg::OP_ADD)
                ctrl.alu_op = lc3b_pkg::ALU_ADD;
            else if (opcode == lc3b_pkg::OP_AND)
                ctrl.alu_op = lc3b_pkg::ALU_AND;
            else
                ctrl.alu_op = lc3b_pkg::ALU_NOT;
            ctrl.reg_write = 1'b1;
        end
        lc3b_pkg::OP_LDB, lc3b_pkg::OP_LDR, lc3b_pkg::OP_LDI:
        begin
            ctrl.alu_op    = lc3b_pkg::ALU_ADD;
            ctrl.reg_write = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.uses_imm  = 1'b1;
        end
        lc3b_pkg::OP_STB, lc3b_pkg::OP_STR, lc3b_pkg::OP_STI:
        begin
            ctrl.alu_op    = lc3b_pkg::ALU_ADD;
            ctrl.mem_read  = (opcode == lc3b_pkg::OP_STI);  // Pointer read first.
            ctrl.mem_write = 1'b1;
            ctrl.uses_imm  = 1'b1;
        end
        lc3b_pkg::OP_JSR, lc3b_pkg::OP_JMP:
        begin
            ctrl.alu_op    = lc3b_pkg::ALU_PASS;
            ctrl.reg_write = (opcode == lc3b_pkg::OP_JSR);  // Link into R7.
            ctrl.branch    = 1'b1;
        end
        lc3b_pkg::OP_SHF, lc3b_pkg::OP_LEA:
        begin
            ctrl.alu_op    = (opcode == lc3b_pkg::OP_SHF) ? lc3b_pkg::ALU_SHF
                                                           : lc3b_pkg::ALU_ADD;
            ctrl.reg_write = 1'b1;
            ctrl.uses_imm  = 1'b1;
        end
        lc3b_pkg::OP_TRAP:
        begin
            ctrl.alu_op    = lc3b_pkg::ALU_PASS;
            ctrl.reg_write = 1'b1;
            ctrl.mem_read  = 1'b1;  // Vector table lookup.
            ctrl.branch    = 1'b1;
            ctrl.is_trap   = 1'b1;
        end
        default:
            ctrl = '0;  // RTI is not supported.
    endcase
end

endmodule : control_rom

// ==== logic/ifid.sv ====
`timescale 1ns/10ps

module ifid
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load,
    input  lc3b_pkg::fetch_packet_t  fetch_in,
    input  logic                     advance,
    output logic                     accept,
    output lc3b_pkg::decode_packet_t decode_out,
    output logic                     decode_valid
);

lc3b_pkg::lc3b_instr_u      instr;
lc3b_pkg::lc3b_control_word rom_ctrl;
lc3b_pkg::decode_packet_t   decoded;

assign instr = fetch_in.instr;

control_rom rom
(
    .opcode (instr.rform.opcode),
    .ctrl   (rom_ctrl)
);

// Room for a new word when empty or when the held one moves on.
assign accept = !decode_valid || advance;

always_comb
begin
    decoded.pc   = fetch_in.pc;
    decoded.dest = instr.rform.dest;
    decoded.src1 = instr.rform.src1;
    decoded.src2 = instr.rform.low[2:0];

    decoded.imm5 = {{11{instr.rform.low[4]}}, instr.rform.low};
    decoded.imm4 = {12'd0, instr.rform.low[3:0]};

    // offset6 spans the flag bit and the low field.
    decoded.offset6  = {{10{instr.rform.imm_flag}}, instr.rform.imm_flag, instr.rform.low};
    decoded.offset9  = {{7{instr.oform.offset9[8]}}, instr.oform.offset9};
    decoded.offset11 = {{5{instr.oform.nzp[1]}}, instr.oform.nzp[1:0],
                        instr.oform.offset9};

    decoded.trapvect8 = {7'd0, instr.oform.offset9[7:0], 1'b0};

    if (instr == '0)
        decoded.ctrl = '0;  // All-zero word is a no-op.
    else
        decoded.ctrl = rom_ctrl;
end

always_ff @(posedge clk)
begin
    if (reset)
        decode_valid <= 1'b0;
    else if (load)
        decode_valid <= 1'b1;
    else if (advance)
        decode_valid <= 1'b0;
end

always_ff @(posedge clk)
begin
    if (load)
        decode_out <= decoded;
end

endmodule : ifid

// ==== logic/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit
#(
    parameter int MEM_ADDR_BITS = 10
)
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    accept,
    input  lc3b_pkg::wb_rsp_t       bus_rsp,
    output lc3b_pkg::wb_req_t       bus_req,
    output logic                    load,
    output lc3b_pkg::fetch_packet_t fetch_out
);

lc3b_pkg::lc3b_word       pc;
logic                     busy;       // Read cycle open on the bus.
logic                     buf_full;
logic [MEM_ADDR_BITS-1:0] word_addr;

// Byte pc to word address, wrapped to the memory window.
assign word_addr = pc[MEM_ADDR_BITS:1];

assign load = buf_full && accept;

always_comb
begin
    bus_req.cyc   = busy;
    bus_req.stb   = busy;
    bus_req.we    = 1'b0;
    bus_req.adr   = {{(16 - MEM_ADDR_BITS){1'b0}}, word_addr};
    bus_req.dat_w = '0;
end

always_ff @(posedge clk)
begin
    if (reset)
    begin
        pc       <= '0;
        busy     <= 1'b0;
        buf_full <= 1'b0;
    end
    else
    begin
        if (busy)
        begin
            if (bus_rsp.ack)
            begin
                busy     <= 1'b0;
                buf_full <= 1'b1;
            end
        end
        else if (load)
        begin
            buf_full <= 1'b0;
            pc       <= pc + 16'd2;
        end
        else if (!buf_full)
            busy <= 1'b1;  // Next read starts the edge after load.
    end
end

always_ff @(posedge clk)
begin
    if (busy && bus_rsp.ack)
    begin
        fetch_out.pc    <= pc;
        fetch_out.instr <= bus_rsp.dat_r;
    end
end

endmodule : fetch_unit

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter
#(
    parameter int MEM_ADDR_BITS = 10
)
(
    input  logic              clk,
    input  logic              reset,
    input  lc3b_pkg::wb_req_t fetch_req,
    input  lc3b_pkg::wb_req_t data_req,
    input  lc3b_pkg::wb_rsp_t mem_rsp,
    output lc3b_pkg::wb_rsp_t fetch_rsp,
    output lc3b_pkg::wb_rsp_t data_rsp,
    output lc3b_pkg::wb_req_t mem_req
);

localparam logic [1:0] GNT_IDLE  = 2'd0;
localparam logic [1:0] GNT_FETCH = 2'd1;
localparam logic [1:0] GNT_DATA  = 2'd2;

logic [1:0]        grant;
logic              fetch_pending;
logic              data_pending;
lc3b_pkg::wb_req_t sel_req;

assign fetch_pending = fetch_req.cyc && fetch_req.stb;
assign data_pending  = data_req.cyc && data_req.stb;

always_ff @(posedge clk)
begin
    if (reset)
        grant <= GNT_IDLE;
    else
    begin
        case (grant)
            GNT_IDLE:
            begin
                if (data_pending)
                    grant <= GNT_DATA;  // Data port wins.
                else if (fetch_pending)
                    grant <= GNT_FETCH;
            end
            default:
            begin
                if (mem_rsp.ack)
                    grant <= GNT_IDLE;  // Released on the ack edge.
            end
        endcase
    end
end

always_comb
begin
    case (grant)
        GNT_FETCH: sel_req = fetch_req;
        GNT_DATA:  sel_req = data_req;
        default:   sel_req = '0;
    endcase

    mem_req     = sel_req;
    mem_req.adr = {{(16 - MEM_ADDR_BITS){1'b0}}, sel_req.adr[MEM_ADDR_BITS-1:0]};
end

// Only the granted master sees the response.
always_comb
begin
    fetch_rsp = '0;
    data_rsp  = '0;
    if (grant == GNT_FETCH)
        fetch_rsp = mem_rsp;
    else if (grant == GNT_DATA)
        data_rsp = mem_rsp;
end

endmodule : mem_arbiter

// ==== logic/lc3b_front_end.sv ====
`timescale 1ns/10ps

module lc3b_front_end
#(
    parameter int MEM_ADDR_BITS = 10
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     advance,
    input  lc3b_pkg::wb_req_t        data_req,
    input  lc3b_pkg::wb_rsp_t        mem_rsp,
    output lc3b_pkg::wb_rsp_t        data_rsp,
    output lc3b_pkg::wb_req_t        mem_req,
    output lc3b_pkg::decode_packet_t decode_out,
    output logic                     decode_valid
);

lc3b_pkg::wb_req_t       fetch_req;
lc3b_pkg::wb_rsp_t       fetch_rsp;
lc3b_pkg::fetch_packet_t fetch_pkt;
logic                    load;
logic                    accept;

fetch_unit #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) fetch
(
    .clk       (clk),
    .reset     (reset),
    .accept    (accept),
    .bus_rsp   (fetch_rsp),
    .bus_req   (fetch_req),
    .load      (load),
    .fetch_out (fetch_pkt)
);

mem_arbiter #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) arbiter
(
    .clk       (clk),
    .reset     (reset),
    .fetch_req (fetch_req),
    .data_req  (data_req),
    .mem_rsp   (mem_rsp),
    .fetch_rsp (fetch_rsp),
    .data_rsp  (data_rsp),
    .mem_req   (mem_req)
);

ifid stage
(
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .fetch_in     (fetch_pkt),
    .advance      (advance),
    .accept       (accept),
    .decode_out   (decode_out),
    .decode_valid (decode_valid)
);

endmodule : lc3b_front_end

// ==== tests/wb_mem_model.sv ====
`timescale 1ns/10ps

module wb_mem_model
#(
    parameter int          MEM_ADDR_BITS = 10,
    parameter logic [31:0] SEED          = 32'h3f91
)
(
    input  logic              clk,
    input  logic              reset,
    input  lc3b_pkg::wb_req_t req,
    output lc3b_pkg::wb_rsp_t rsp
);

localparam int DEPTH = 2 ** MEM_ADDR_BITS;

lc3b_pkg::lc3b_word       mem [0:DEPTH-1];
logic [31:0]              rng;
logic [1:0]               wait_left;
logic [MEM_ADDR_BITS-1:0] index;

function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

assign index = req.adr[MEM_ADDR_BITS-1:0];

initial
begin
    logic [31:0] state;
    state = SEED;
    for (int i = 0; i < DEPTH; i++)
    begin
        state = lcg_step(state);
        if (i < DEPTH / 2 && i % 8 == 7)
            mem[i] = '0;  // Every eighth code word is a no-op.
        else
            mem[i] = state[31:16] ^ i[15:0];
    end
end

always @(posedge clk)
begin
    if (reset)
    begin
        rsp       <= '0;
        rng       <= SEED;
        wait_left <= 2'd0;
    end
    else if (rsp.ack)
    begin
        rsp.ack   <= 1'b0;  // One ack per transfer.
        rng       <= lcg_step(rng);
        wait_left <= rng[17:16];
    end
    else if (req.cyc && req.stb)
    begin
        if (wait_left == 2'd0)
        begin
            rsp.ack   <= 1'b1;
            rsp.dat_r <= mem[index];
            if (req.we)
                mem[index] <= req.dat_w;
        end
        else
            wait_left <= wait_left - 2'd1;
    end
end

endmodule : wb_mem_model

// ==== tests/tb_front_end.sv ====
`timescale 1ns/10ps

module tb_front_end;

localparam int          MEM_ADDR_BITS   = 10;
localparam logic [31:0] SEED            = 32'h3f91;
localparam int          NUM_INSTR       = 400;
localparam int          DATA_PAIRS      = 32;
localparam int          DATA_BASE       = 2 ** (MEM_ADDR_BITS - 1);  // High half of memory.
localparam int          DATA_CYCLES     = DATA_PAIRS * 2 * 12;
localparam int          WATCHDOG_CYCLES = NUM_INSTR * 12 + DATA_CYCLES;

logic                     clk;
logic                     reset;
logic                     advance;
lc3b_pkg::wb_req_t        data_req;
lc3b_pkg::wb_rsp_t        data_rsp;
lc3b_pkg::wb_req_t        mem_req;
lc3b_pkg::wb_rsp_t        mem_rsp;
lc3b_pkg::decode_packet_t decode_out;
logic                     decode_valid;

int   decode_errors = 0;
int   data_errors   = 0;
int   reset_errors  = 0;
int   instr_count   = 0;
int   noop_count    = 0;
logic reset_checked = 1'b0;
logic data_done     = 1'b0;

lc3b_front_end #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) uut
(
    .clk          (clk),
    .reset        (reset),
    .advance      (advance),
    .data_req     (data_req),
    .mem_rsp      (mem_rsp),
    .data_rsp     (data_rsp),
    .mem_req      (mem_req),
    .decode_out   (decode_out),
    .decode_valid (decode_valid)
);

wb_mem_model #(.MEM_ADDR_BITS(MEM_ADDR_BITS), .SEED(SEED)) mem_model
(
    .clk   (clk),
    .reset (reset),
    .req   (mem_req),
    .rsp   (mem_rsp)
);

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

// Control word bits are alu_op, then reg_write, mem_read, mem_write, branch, uses_imm, is_trap.
function automatic lc3b_pkg::lc3b_control_word expected_ctrl(input logic [3:0] opcode);
    lc3b_pkg::lc3b_control_word ctrl;
    case (opcode)
        4'h0: ctrl = {3'd0, 6'b000100};
        4'h1: ctrl = {3'd0, 6'b100000};
        4'h2: ctrl = {3'd0, 6'b110010};
        4'h3: ctrl = {3'd0, 6'b001010};
        4'h4: ctrl = {3'd3, 6'b100100};
        4'h5: ctrl = {3'd1, 6'b100000};
        4'h6: ctrl = {3'd0, 6'b110010};
        4'h7: ctrl = {3'd0, 6'b001010};
        4'h9: ctrl = {3'd2, 6'b100000};
        4'hA: ctrl = {3'd0, 6'b110010};
        4'hB: ctrl = {3'd0, 6'b011010};
        4'hC: ctrl = {3'd3, 6'b000100};
        4'hD: ctrl = {3'd4, 6'b100010};
        4'hE: ctrl = {3'd0, 6'b100010};
        4'hF: ctrl = {3'd3, 6'b110101};
        default: ctrl = '0;  // RTI.
    endcase
    return ctrl;
endfunction

function automatic lc3b_pkg::decode_packet_t expected_decode(input lc3b_pkg::lc3b_word instr,
                                                             input lc3b_pkg::lc3b_word pc);
    lc3b_pkg::decode_packet_t pkt;
    pkt.pc        = pc;
    pkt.dest      = instr[11:9];
    pkt.src1      = instr[8:6];
    pkt.src2      = instr[2:0];
    pkt.imm5      = {{11{instr[4]}}, instr[4:0]};
    pkt.imm4      = {12'd0, instr[3:0]};
    pkt.offset6   = {{10{instr[5]}}, instr[5:0]};
    pkt.offset9   = {{7{instr[8]}}, instr[8:0]};
    pkt.offset11  = {{5{instr[10]}}, instr[10:0]};
    pkt.trapvect8 = {7'd0, instr[7:0], 1'b0};
    pkt.ctrl      = (instr == 16'h0000) ? '0 : expected_ctrl(instr[15:12]);
    return pkt;
endfunction

task automatic compare_word(input string name, input lc3b_pkg::lc3b_word expected,
                            input lc3b_pkg::lc3b_word actual, inout int errors);
    assert (actual == expected)
    else
    begin
        $display("ERR at %0t: %s expected %h, got %h", $time, name, expected, actual);
        errors++;
    end
endtask

task automatic check_idle();
    compare_word("decode_valid", 16'h0000, {15'd0, decode_valid}, reset_errors);
    compare_word("data_rsp.ack", 16'h0000, {15'd0, data_rsp.ack}, reset_errors);
    compare_word("mem_req.cyc", 16'h0000, {15'd0, mem_req.cyc}, reset_errors);
    compare_word("mem_req.stb", 16'h0000, {15'd0, mem_req.stb}, reset_errors);
endtask

task automatic check_decode(input lc3b_pkg::decode_packet_t exp);
    compare_word("decode_out.pc", exp.pc, decode_out.pc, decode_errors);
    compare_word("decode_out.dest", {13'd0, exp.dest}, {13'd0, decode_out.dest}, decode_errors);
    compare_word("decode_out.src1", {13'd0, exp.src1}, {13'd0, decode_out.src1}, decode_errors);
    compare_word("decode_out.src2", {13'd0, exp.src2}, {13'd0, decode_out.src2}, decode_errors);
    compare_word("decode_out.imm5", exp.imm5, decode_out.imm5, decode_errors);
    compare_word("decode_out.imm4", exp.imm4, decode_out.imm4, decode_errors);
    compare_word("decode_out.offset6", exp.offset6, decode_out.offset6, decode_errors);
    compare_word("decode_out.offset9", exp.offset9, decode_out.offset9, decode_errors);
    compare_word("decode_out.offset11", exp.offset11, decode_out.offset11, decode_errors);
    compare_word("decode_out.trapvect8", exp.trapvect8, decode_out.trapvect8, decode_errors);
    compare_word("decode_out.ctrl", {7'd0, exp.ctrl}, {7'd0, decode_out.ctrl}, decode_errors);
endtask

// One Wishbone classic transfer on the data port.
task automatic bus_access(input logic write, input lc3b_pkg::lc3b_word adr,
                          input lc3b_pkg::lc3b_word wdata, output lc3b_pkg::lc3b_word rdata);
    lc3b_pkg::wb_req_t req;
    req.cyc   = 1'b1;
    req.stb   = 1'b1;
    req.we    = write;
    req.adr   = adr;
    req.dat_w = wdata;
    @(posedge clk);
    data_req <= req;
    @(negedge clk);
    while (!data_rsp.ack)
        @(negedge clk);
    rdata = data_rsp.dat_r;
    @(posedge clk);
    data_req <= '0;  // Transfer completes on this edge.
endtask

task automatic report_counts();
    $display("Errors: decode %0d, data %0d, reset %0d; %0d instructions, %0d no-ops checked",
             decode_errors, data_errors, reset_errors, instr_count, noop_count);
endtask

initial
begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

initial
begin
    logic [31:0] adv_rng;
    adv_rng  = SEED;
    reset    = 1'b1;
    advance  = 1'b0;
    data_req = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    forever
    begin
        adv_rng = lcg_next(adv_rng);
        advance <= 1'b1;
        repeat (1 + adv_rng[18:16]) @(posedge clk);
        adv_rng = lcg_next(adv_rng);
        advance <= 1'b0;
        repeat (adv_rng[19:16] % 11) @(posedge clk);  // Stall of 0 to 10 cycles.
    end
end

initial
begin
    @(negedge clk);
    while (reset)
    begin
        check_idle();
        @(negedge clk);
    end
    check_idle();
    @(negedge clk);
    check_idle();  // After the first edge out of reset.
    while (!(mem_req.cyc && mem_req.stb))
        @(negedge clk);
    compare_word("mem_req.adr", 16'h0000, mem_req.adr, reset_errors);
    compare_word("mem_req.we", 16'h0000, {15'd0, mem_req.we}, reset_errors);
    reset_checked = 1'b1;
end

initial
begin
    logic [31:0]        data_rng;
    logic [5:0]         offsets [DATA_PAIRS];
    lc3b_pkg::lc3b_word shadow [64];
    lc3b_pkg::lc3b_word wdata;
    lc3b_pkg::lc3b_word rdata;
    data_rng = ~SEED;
    wait (reset_checked);
    for (int i = 0; i < DATA_PAIRS; i++)
    begin
        data_rng   = lcg_next(data_rng);
        offsets[i] = data_rng[21:16];
        data_rng   = lcg_next(data_rng);
        wdata      = data_rng[31:16];
        bus_access(1'b1, 16'(DATA_BASE + offsets[i]), wdata, rdata);
        shadow[offsets[i]] = wdata;  // Last value written wins.
        repeat (data_rng[27:25]) @(posedge clk);
    end
    for (int i = 0; i < DATA_PAIRS; i++)
    begin
        bus_access(1'b0, 16'(DATA_BASE + offsets[i]), 16'h0000, rdata);
        compare_word("data_rsp.dat_r", shadow[offsets[i]], rdata, data_errors);
    end
    data_done = 1'b1;
end

initial
begin
    lc3b_pkg::lc3b_word       exp_pc;
    lc3b_pkg::decode_packet_t held_pkt;
    logic                     holding;
    exp_pc   = '0;
    held_pkt = '0;
    holding  = 1'b0;
    forever
    begin
        @(negedge clk);
        if (holding)
        begin
            compare_word("decode_valid", 16'h0001, {15'd0, decode_valid}, decode_errors);
            assert (decode_out == held_pkt)
            else
            begin
                $display("ERR at %0t: decode_out expected %h, got %h",
                         $time, held_pkt, decode_out);
                decode_errors++;
            end
        end
        holding  = !reset && decode_valid && !advance;
        held_pkt = decode_out;
        if (!reset && decode_valid && advance && instr_count < NUM_INSTR)
        begin
            check_decode(expected_decode(mem_model.mem[exp_pc[MEM_ADDR_BITS:1]], exp_pc));
            if (exp_pc[3:1] == 3'd7)
            begin
                compare_word("decode_out.ctrl", 16'h0000, {7'd0, decode_out.ctrl},
                             decode_errors);
                noop_count++;
            end
            instr_count++;
            exp_pc = exp_pc + 16'd2;
        end
    end
end

initial
begin
    wait (instr_count == NUM_INSTR && data_done);
    report_counts();
    if (decode_errors + data_errors + reset_errors == 0)
        $display("Finished with no errors");
    else
        $display("Finished with errors");
    $finish;
end

initial
begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d instructions decoded",
             WATCHDOG_CYCLES, instr_count, NUM_INSTR);
    report_counts();
    $display("Finished with errors");
    $finish;
end

endmodule : tb_front_end

// ==== sim.f ====
logic/lc3b_pkg.sv
logic/control_rom.sv
logic/ifid.sv
logic/fetch_unit.sv
logic/mem_arbiter.sv
logic/lc3b_front_end.sv
tests/wb_mem_model.sv
tests/tb_front_end.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_front_end -o tb_front_end

output=$(./obj_dir/tb_front_end)
echo "$output"

if echo "$output" | grep -q "^Finished with no errors$"; then
    exit 0
fi
exit 1
